/* hdl/udp_defs.svh */
`ifndef UDP_DEFS_SVH
`define UDP_DEFS_SVH

// Transmit buffer depth in bytes
`define UDP_MAX_PAYLOAD 64

`define UDP_HDR_BYTES 8

// Well known DHCP ports
`define DHCP_CLIENT_PORT 16'd68
`define DHCP_SERVER_PORT 16'd67

// Reduced message: op, type, xid, address
`define DHCP_MSG_BYTES 10

// Wait for an answer before a resend
`define DHCP_TIMEOUT_CYCLES 2000

`define DHCP_RETRIES 3

`define DHCP_XID 32'h3903_F326

`endif

/* hdl/udp_pkg.sv */
package udp_pkg;

  // One byte of a stream
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_strm_t;

  // IPv4 side packet description
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] length;
  } ipv4_meta_t;

  // Wire order is most significant byte first
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] chksum;
  } udp_hdr_t;

  // Datagram description with payload length only
  typedef struct packed {
    logic [31:0] rem_ip;
    logic [15:0] rem_port;
    logic [15:0] loc_port;
    logic [15:0] length;
  } udp_meta_t;

  typedef struct packed {
    logic [15:0] loc_port;
    logic [15:0] rem_port;
    logic [31:0] rem_ip;
  } udp_ctl_t;

  typedef enum logic [2:0] {
    IDLE,
    DISCOVER,
    WAIT_OFFER,
    REQUEST,
    WAIT_ACK,
    BOUND,
    FAILED
  } dhcp_state_t;

  typedef struct packed {
    logic        bound;
    logic        failed;
    logic [31:0] ip;
  } dhcp_stat_t;

endpackage : udp_pkg

/* hdl/udp_tx_ctl.sv */
`timescale 1ns/1ps
`include "udp_defs.svh"

module udp_tx_ctl (
  input  logic                clk,
  input  logic                rst_n,
  input  udp_pkg::byte_strm_t in,
  input  logic                in_valid,
  output logic                in_ready,
  input  udp_pkg::udp_ctl_t   ctl,
  output udp_pkg::byte_strm_t out,
  output udp_pkg::udp_meta_t  out_meta,
  output logic                out_valid,
  input  logic                out_ready
);

  localparam int DEPTH = `UDP_MAX_PAYLOAD;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [7:0]       mem [DEPTH];
  logic [CNT_W-1:0] wr_cnt;
  logic [PTR_W-1:0] rd_ptr;
  logic             draining;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full     = (wr_cnt == CNT_W'(DEPTH));
  assign in_ready = !draining;
  assign wr_en    = in_valid && in_ready;
  assign rd_en    = out_valid && out_ready;

  // Overflow bytes are dropped but last still ends the fill
  always_ff @(posedge clk) begin
    if (wr_en && !full) begin
      mem[wr_cnt[PTR_W-1:0]] <= in.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_cnt   <= '0;
      rd_ptr   <= '0;
      draining <= 1'b0;
    end else if (!draining) begin
      if (wr_en) begin
        if (!full) begin
          wr_cnt <= wr_cnt + CNT_W'(1);
        end
        if (in.last) begin
          draining <= 1'b1;
        end
      end
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + PTR_W'(1);
      if (out.last) begin
        rd_ptr   <= '0;
        wr_cnt   <= '0;
        draining <= 1'b0;
      end
    end
  end

  assign out_valid = draining;
  assign out.data  = mem[rd_ptr];
  assign out.last  = (CNT_W'(rd_ptr) + CNT_W'(1) == wr_cnt);

  assign out_meta = '{
    rem_ip:   ctl.rem_ip,
    rem_port: ctl.rem_port,
    loc_port: ctl.loc_port,
    length:   16'(wr_cnt)
  };

endmodule : udp_tx_ctl

/* hdl/udp_core.sv */
`timescale 1ns/1ps
`include "udp_defs.svh"

module udp_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         loc_ip,
  input  udp_pkg::byte_strm_t ipv4_rx,
  input  udp_pkg::ipv4_meta_t ipv4_rx_meta,
  input  logic                ipv4_rx_valid,
  output logic                ipv4_rx_ready,
  output udp_pkg::byte_strm_t ipv4_tx,
  output udp_pkg::ipv4_meta_t ipv4_tx_meta,
  output logic                ipv4_tx_valid,
  input  logic                ipv4_tx_ready,
  input  udp_pkg::byte_strm_t tx,
  input  udp_pkg::udp_meta_t  tx_meta,
  input  logic                tx_valid,
  output logic                tx_ready,
  input  logic [15:0]         usr_port,
  output udp_pkg::byte_strm_t usr_rx,
  output udp_pkg::udp_meta_t  usr_rx_meta,
  output logic                usr_rx_valid,
  input  logic                usr_rx_ready,
  output udp_pkg::byte_strm_t dhcp_rx,
  output udp_pkg::udp_meta_t  dhcp_rx_meta,
  output logic                dhcp_rx_valid
);

  localparam logic [1:0] T_IDLE   = 2'd0;
  localparam logic [1:0] T_HDR    = 2'd1;
  localparam logic [1:0] T_PLD    = 2'd2;
  localparam logic [1:0] R_HDR    = 2'd0;
  localparam logic [1:0] R_USR    = 2'd1;
  localparam logic [1:0] R_DHCP   = 2'd2;
  localparam logic [1:0] R_DROP   = 2'd3;
  localparam logic [2:0] HDR_LAST = 3'(`UDP_HDR_BYTES - 1);

  logic [1:0]         tx_st;
  logic [2:0]         tx_cnt;
  logic [63:0]        tx_sr;
  logic [15:0]        tx_len;
  udp_pkg::udp_hdr_t  tx_hdr;
  logic [1:0]         rx_st;
  logic [2:0]         rx_cnt;
  logic [55:0]        rx_sr;
  udp_pkg::udp_hdr_t  rx_hdr;
  udp_pkg::udp_meta_t rx_meta_q;

  assign tx_len = 16'(tx_meta.length + `UDP_HDR_BYTES);
  assign tx_hdr = '{src_port: tx_meta.loc_port, dst_port: tx_meta.rem_port,
                    length: tx_len, chksum: 16'h0000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_st  <= T_IDLE;
      tx_cnt <= '0;
    end else begin
      case (tx_st)
        T_IDLE: begin
          tx_cnt <= '0;
          if (tx_valid) begin
            tx_st <= T_HDR;
          end
        end
        T_HDR: begin
          if (ipv4_tx_ready) begin
            tx_cnt <= tx_cnt + 3'd1;
            if (tx_cnt == HDR_LAST) begin
              tx_st <= T_PLD;
            end
          end
        end
        T_PLD: begin
          if (tx_valid && ipv4_tx_ready && tx.last) begin
            tx_st <= T_IDLE;
          end
        end
        default: tx_st <= T_IDLE;
      endcase
    end
  end

  // Header shifts out MSB first
  always_ff @(posedge clk) begin
    if (tx_st == T_IDLE && tx_valid) begin
      tx_sr        <= tx_hdr;
      ipv4_tx_meta <= '{src_ip: loc_ip, dst_ip: tx_meta.rem_ip, length: tx_len};
    end else if (tx_st == T_HDR && ipv4_tx_ready) begin
      tx_sr <= {tx_sr[55:0], 8'h00};
    end
  end

  always_comb begin
    ipv4_tx       = '0;
    ipv4_tx_valid = 1'b0;
    tx_ready      = 1'b0;
    if (tx_st == T_HDR) begin
      ipv4_tx.data  = tx_sr[63:56];
      ipv4_tx_valid = 1'b1;
    end else if (tx_st == T_PLD) begin
      ipv4_tx       = tx;
      ipv4_tx_valid = tx_valid;
      tx_ready      = ipv4_tx_ready;
    end
  end

  assign rx_hdr = {rx_sr, ipv4_rx.data};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_st  <= R_HDR;
      rx_cnt <= '0;
    end else if (ipv4_rx_valid && ipv4_rx_ready) begin
      if (rx_st == R_HDR) begin
        rx_cnt <= rx_cnt + 3'd1;
        if (ipv4_rx.last) begin
          // Truncated or empty datagram
          rx_cnt <= '0;
        end else if (rx_cnt == HDR_LAST) begin
          if (rx_hdr.dst_port == `DHCP_CLIENT_PORT) begin
            rx_st <= R_DHCP;
          end else if (rx_hdr.dst_port == usr_port) begin
            rx_st <= R_USR;
          end else begin
            rx_st <= R_DROP;
          end
        end
      end else if (ipv4_rx.last) begin
        rx_st <= R_HDR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_st == R_HDR && ipv4_rx_valid) begin
      rx_sr     <= {rx_sr[47:0], ipv4_rx.data};
      rx_meta_q <= '{rem_ip: ipv4_rx_meta.src_ip, rem_port: rx_hdr.src_port,
                     loc_port: rx_hdr.dst_port,
                     length: 16'(rx_hdr.length - `UDP_HDR_BYTES)};
    end
  end

  assign usr_rx        = ipv4_rx;
  assign usr_rx_meta   = rx_meta_q;
  assign usr_rx_valid  = (rx_st == R_USR) && ipv4_rx_valid;
  assign dhcp_rx       = ipv4_rx;
  assign dhcp_rx_meta  = rx_meta_q;
  assign dhcp_rx_valid = (rx_st == R_DHCP) && ipv4_rx_valid;
  // Only the user path pushes back
  assign ipv4_rx_ready = (rx_st == R_USR) ? usr_rx_ready : 1'b1;

endmodule : udp_core

/* hdl/dhcp_client.sv */
`timescale 1ns/1ps
`include "udp_defs.svh"

module dhcp_client (
  input  logic                clk,
  input  logic                rst_n,
  input  udp_pkg::byte_strm_t rx,
  input  udp_pkg::udp_meta_t  rx_meta,
  input  logic                rx_valid,
  output udp_pkg::byte_strm_t tx,
  output udp_pkg::udp_meta_t  tx_meta,
  output logic                tx_valid,
  input  logic                tx_ready,
  output logic                txe,
  output udp_pkg::dhcp_stat_t stat
);

  localparam int             MSG_W     = 8 * `DHCP_MSG_BYTES;
  localparam logic [3:0]     MSG_LAST  = 4'(`DHCP_MSG_BYTES - 1);
  localparam int             TMR_W     = $clog2(`DHCP_TIMEOUT_CYCLES);
  localparam logic [TMR_W-1:0] TMR_END = TMR_W'(`DHCP_TIMEOUT_CYCLES - 1);
  localparam int             RTY_W     = $clog2(`DHCP_RETRIES + 1);
  localparam logic [RTY_W-1:0] RTY_MAX = RTY_W'(`DHCP_RETRIES);
  localparam logic [7:0]     OP_REQ    = 8'd1;
  localparam logic [7:0]     OP_REPLY  = 8'd2;
  localparam logic [7:0]     T_DISC    = 8'd1;
  localparam logic [7:0]     T_OFFER   = 8'd2;
  localparam logic [7:0]     T_REQ     = 8'd3;
  localparam logic [7:0]     T_ACK     = 8'd5;

  udp_pkg::dhcp_state_t state;
  logic [MSG_W-1:0]     msg_sr;
  logic [3:0]           tx_cnt;
  logic [TMR_W-1:0]     timer;
  logic [RTY_W-1:0]     retry;
  logic [31:0]          offer_ip;
  logic [31:0]          lease_ip;
  logic [MSG_W-9:0]     rx_sr;
  logic [3:0]           rx_cnt;
  logic [MSG_W-1:0]     rx_msg;
  logic                 rx_done;
  logic                 offer_ok;
  logic                 ack_ok;
  logic                 timeout;

  function automatic logic [MSG_W-1:0] build_msg(input logic [7:0] mtype,
                                                 input logic [31:0] addr);
    build_msg = {OP_REQ, mtype, `DHCP_XID, addr};
  endfunction

  // Receive side keeps the last message bytes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_cnt <= '0;
    end else if (rx_valid) begin
      if (rx.last) begin
        rx_cnt <= '0;
      end else if (rx_cnt != 4'hf) begin
        rx_cnt <= rx_cnt + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rx_sr <= {rx_sr[MSG_W-17:0], rx.data};
    end
  end

  assign rx_msg  = {rx_sr, rx.data};
  assign rx_done = rx_valid && rx.last && (rx_cnt == MSG_LAST);
  assign offer_ok = rx_done && (rx_meta.rem_port == `DHCP_SERVER_PORT) &&
                    (rx_msg[79:72] == OP_REPLY) && (rx_msg[71:64] == T_OFFER) &&
                    (rx_msg[63:32] == `DHCP_XID);
  assign ack_ok   = rx_done && (rx_msg[71:64] == T_ACK) &&
                    (rx_msg[63:32] == `DHCP_XID) && (rx_msg[31:0] == offer_ip);
  assign timeout  = (timer == TMR_END);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= udp_pkg::IDLE;
      tx_cnt   <= '0;
      timer    <= '0;
      retry    <= '0;
      lease_ip <= '0;
    end else begin
      case (state)
        udp_pkg::IDLE: state <= udp_pkg::DISCOVER;
        udp_pkg::DISCOVER, udp_pkg::REQUEST: begin
          timer <= '0;
          if (tx_valid && tx_ready) begin
            tx_cnt <= tx_cnt + 4'd1;
            if (tx.last) begin
              tx_cnt <= '0;
              state  <= (state == udp_pkg::DISCOVER) ? udp_pkg::WAIT_OFFER
                                                     : udp_pkg::WAIT_ACK;
            end
          end
        end
        udp_pkg::WAIT_OFFER, udp_pkg::WAIT_ACK: begin
          timer <= timer + TMR_W'(1);
          if (state == udp_pkg::WAIT_OFFER && offer_ok) begin
            state <= udp_pkg::REQUEST;
            retry <= '0;
          end else if (state == udp_pkg::WAIT_ACK && ack_ok) begin
            state    <= udp_pkg::BOUND;
            lease_ip <= offer_ip;
          end else if (timeout) begin
            if (retry == RTY_MAX) begin
              state <= udp_pkg::FAILED;
            end else begin
              retry <= retry + RTY_W'(1);
              state <= (state == udp_pkg::WAIT_OFFER) ? udp_pkg::DISCOVER
                                                      : udp_pkg::REQUEST;
            end
          end
        end
        default: state <= state;
      endcase
    end
  end

  // Message builder reloaded before each send
  always_ff @(posedge clk) begin
    if (state == udp_pkg::IDLE || (state == udp_pkg::WAIT_OFFER && !offer_ok && timeout)) begin
      msg_sr <= build_msg(T_DISC, 32'h0);
    end else if (state == udp_pkg::WAIT_OFFER && offer_ok) begin
      msg_sr   <= build_msg(T_REQ, rx_msg[31:0]);
      offer_ip <= rx_msg[31:0];
    end else if (state == udp_pkg::WAIT_ACK && !ack_ok && timeout) begin
      msg_sr <= build_msg(T_REQ, offer_ip);
    end else if (tx_valid && tx_ready) begin
      msg_sr <= {msg_sr[MSG_W-9:0], 8'h00};
    end
  end

  assign tx_valid = (state == udp_pkg::DISCOVER) || (state == udp_pkg::REQUEST);
  assign tx.data  = msg_sr[MSG_W-1 -: 8];
  assign tx.last  = (tx_cnt == MSG_LAST);
  // Broadcast to the server port
  assign tx_meta  = '{rem_ip: 32'hffff_ffff, rem_port: `DHCP_SERVER_PORT,
                      loc_port: `DHCP_CLIENT_PORT, length: 16'(`DHCP_MSG_BYTES)};

  assign stat.bound  = (state == udp_pkg::BOUND);
  assign stat.failed = (state == udp_pkg::FAILED);
  assign stat.ip     = lease_ip;
  assign txe         = !(stat.bound || stat.failed);

endmodule : dhcp_client

/* hdl/udp_top.sv */
`timescale 1ns/1ps

module udp_top (
  input  logic                clk,
  input  logic                rst_n,
  input  udp_pkg::byte_strm_t ipv4_rx,
  input  udp_pkg::ipv4_meta_t ipv4_rx_meta,
  input  logic                ipv4_rx_valid,
  output logic                ipv4_rx_ready,
  output udp_pkg::byte_strm_t ipv4_tx,
  output udp_pkg::ipv4_meta_t ipv4_tx_meta,
  output logic                ipv4_tx_valid,
  input  logic                ipv4_tx_ready,
  input  udp_pkg::byte_strm_t usr_tx,
  input  logic                usr_tx_valid,
  output logic                usr_tx_ready,
  input  udp_pkg::udp_ctl_t   usr_ctl,
  output udp_pkg::byte_strm_t usr_rx,
  output udp_pkg::udp_meta_t  usr_rx_meta,
  output logic                usr_rx_valid,
  input  logic                usr_rx_ready,
  output udp_pkg::dhcp_stat_t dhcp_stat
);

  udp_pkg::byte_strm_t ctl_tx, dhcp_tx, core_tx, dhcp_rx;
  udp_pkg::udp_meta_t  ctl_tx_meta, dhcp_tx_meta, core_tx_meta, dhcp_rx_meta;
  logic                ctl_tx_valid, ctl_tx_ready;
  logic                dhcp_tx_valid, dhcp_tx_ready;
  logic                core_tx_valid, core_tx_ready;
  logic                dhcp_rx_valid;
  logic                txe;

  udp_tx_ctl u_tx_ctl (
    .clk (clk), .rst_n (rst_n),
    .in (usr_tx), .in_valid (usr_tx_valid), .in_ready (usr_tx_ready), .ctl (usr_ctl),
    .out (ctl_tx), .out_meta (ctl_tx_meta), .out_valid (ctl_tx_valid),
    .out_ready (ctl_tx_ready)
  );

  // DHCP owns the transmit path until it holds a lease or gives up
  assign core_tx       = txe ? dhcp_tx       : ctl_tx;
  assign core_tx_meta  = txe ? dhcp_tx_meta  : ctl_tx_meta;
  assign core_tx_valid = txe ? dhcp_tx_valid : ctl_tx_valid;
  assign dhcp_tx_ready = txe && core_tx_ready;
  assign ctl_tx_ready  = !txe && core_tx_ready;

  udp_core u_core (
    .clk (clk), .rst_n (rst_n), .loc_ip (dhcp_stat.ip),
    .ipv4_rx (ipv4_rx), .ipv4_rx_meta (ipv4_rx_meta),
    .ipv4_rx_valid (ipv4_rx_valid), .ipv4_rx_ready (ipv4_rx_ready),
    .ipv4_tx (ipv4_tx), .ipv4_tx_meta (ipv4_tx_meta),
    .ipv4_tx_valid (ipv4_tx_valid), .ipv4_tx_ready (ipv4_tx_ready),
    .tx (core_tx), .tx_meta (core_tx_meta), .tx_valid (core_tx_valid),
    .tx_ready (core_tx_ready), .usr_port (usr_ctl.loc_port),
    .usr_rx (usr_rx), .usr_rx_meta (usr_rx_meta),
    .usr_rx_valid (usr_rx_valid), .usr_rx_ready (usr_rx_ready),
    .dhcp_rx (dhcp_rx), .dhcp_rx_meta (dhcp_rx_meta), .dhcp_rx_valid (dhcp_rx_valid)
  );

  dhcp_client u_dhcp (
    .clk (clk), .rst_n (rst_n),
    .rx (dhcp_rx), .rx_meta (dhcp_rx_meta), .rx_valid (dhcp_rx_valid),
    .tx (dhcp_tx), .tx_meta (dhcp_tx_meta), .tx_valid (dhcp_tx_valid),
    .tx_ready (dhcp_tx_ready), .txe (txe), .stat (dhcp_stat)
  );

endmodule : udp_top

/* sim/udp_tb.sv */
`timescale 1ns/1ps
`include "udp_defs.svh"

module udp_tb;

  localparam int CLK_NS    = 4;
  localparam int TX_PKTS   = 20;
  localparam int RX_PKTS   = 8;
  localparam int DROP_PKTS = 3;
  // Three DHCP messages each way plus the payload loaded during DHCP
  localparam int N_PKTS      = 6 + 1 + TX_PKTS + RX_PKTS + DROP_PKTS;
  localparam int CYCLE_LIMIT = 4 * `DHCP_TIMEOUT_CYCLES + 200 * N_PKTS;
  localparam logic [31:0] SERVER_IP = 32'h0a00_0001;
  localparam logic [31:0] OFFER_IP  = 32'h0a00_0064;
  localparam logic [15:0] USR_PORT  = 16'd5000;

  typedef logic [7:0] byte_q_t[$];

  logic                clk;
  logic                rst_n;
  udp_pkg::byte_strm_t ipv4_rx, ipv4_tx, usr_tx, usr_rx;
  udp_pkg::ipv4_meta_t ipv4_rx_meta, ipv4_tx_meta;
  logic                ipv4_rx_valid, ipv4_rx_ready, ipv4_tx_valid, ipv4_tx_ready;
  logic                usr_tx_valid, usr_tx_ready, usr_rx_valid, usr_rx_ready;
  udp_pkg::udp_ctl_t   usr_ctl;
  udp_pkg::udp_meta_t  usr_rx_meta;
  udp_pkg::dhcp_stat_t dhcp_stat;

  udp_pkg::byte_strm_t exp_tx[$];
  udp_pkg::byte_strm_t exp_rx[$];
  udp_pkg::ipv4_meta_t exp_tx_meta[$];
  udp_pkg::udp_meta_t  exp_rx_meta[$];
  int                  val_errs = 0;
  int                  proto_errs = 0;
  int                  tx_done = 0;
  int                  rx_done = 0;
  bit                  tx_first = 1'b1;
  bit                  rx_first = 1'b1;
  time                 tx_start, tx_end;

  udp_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Random gaps on both ready inputs
  always @(posedge clk) begin
    ipv4_tx_ready <= ($urandom % 4) != 0;
    usr_rx_ready  <= ($urandom % 3) != 0;
  end

  // UDP header MSB first with the length over header and payload and a zero checksum
  function automatic byte_q_t udp_bytes(input logic [15:0] sp, input logic [15:0] dp,
                                        input byte_q_t pld);
    byte_q_t     pkt;
    logic [63:0] hdr;
    hdr = {sp, dp, 16'(pld.size() + `UDP_HDR_BYTES), 16'h0000};
    for (int i = `UDP_HDR_BYTES - 1; i >= 0; i--) begin
      pkt.push_back(hdr[8*i +: 8]);
    end
    foreach (pld[i]) begin
      pkt.push_back(pld[i]);
    end
    return pkt;
  endfunction

  function automatic byte_q_t dhcp_bytes(input logic [7:0] op, input logic [7:0] mtype,
                                         input logic [31:0] xid, input logic [31:0] addr);
    byte_q_t     msg;
    logic [79:0] w;
    w = {op, mtype, xid, addr};
    for (int i = `DHCP_MSG_BYTES - 1; i >= 0; i--) begin
      msg.push_back(w[8*i +: 8]);
    end
    return msg;
  endfunction

  function automatic byte_q_t rand_payload(input int max_len);
    byte_q_t pld;
    int      n;
    n = 1 + int'($urandom % max_len);
    for (int i = 0; i < n; i++) begin
      pld.push_back(8'($urandom));
    end
    return pld;
  endfunction

  function automatic void expect_tx(input logic [15:0] sp, input logic [15:0] dp,
                                    input logic [31:0] sip, input logic [31:0] dip,
                                    input byte_q_t pld);
    byte_q_t             pkt;
    udp_pkg::byte_strm_t b;
    udp_pkg::ipv4_meta_t m;
    pkt = udp_bytes(sp, dp, pld);
    foreach (pkt[i]) begin
      b.data = pkt[i];
      b.last = (i == pkt.size() - 1);
      exp_tx.push_back(b);
    end
    m.src_ip = sip;
    m.dst_ip = dip;
    m.length = 16'(pkt.size());
    exp_tx_meta.push_back(m);
  endfunction

  function automatic void expect_rx(input logic [31:0] sip, input logic [15:0] sp,
                                    input byte_q_t pld);
    udp_pkg::byte_strm_t b;
    udp_pkg::udp_meta_t  m;
    foreach (pld[i]) begin
      b.data = pld[i];
      b.last = (i == pld.size() - 1);
      exp_rx.push_back(b);
    end
    m.rem_ip   = sip;
    m.rem_port = sp;
    m.loc_port = USR_PORT;
    m.length   = 16'(pld.size());
    exp_rx_meta.push_back(m);
  endfunction

  task automatic check_ipv4_byte(input udp_pkg::byte_strm_t got,
                                 input udp_pkg::byte_strm_t exp, input string what);
    if (got !== exp) begin
      val_errs++;
      $display("error %0t: %s byte %h last %b, expected %h last %b", $time, what,
               got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_ipv4_meta(input udp_pkg::ipv4_meta_t got,
                                 input udp_pkg::ipv4_meta_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("error %0t: ipv4_tx_meta %h/%h/%0d, expected %h/%h/%0d", $time,
               got.src_ip, got.dst_ip, got.length, exp.src_ip, exp.dst_ip, exp.length);
    end
  endtask

  task automatic check_udp_meta(input udp_pkg::udp_meta_t got, input udp_pkg::udp_meta_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("error %0t: usr_rx_meta %h/%0d/%0d/%0d, expected %h/%0d/%0d/%0d", $time,
               got.rem_ip, got.rem_port, got.loc_port, got.length,
               exp.rem_ip, exp.rem_port, exp.loc_port, exp.length);
    end
  endtask

  task automatic check_stat(input udp_pkg::dhcp_stat_t got, input udp_pkg::dhcp_stat_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("error %0t: dhcp_stat bound %b failed %b ip %h, expected %b %b %h", $time,
               got.bound, got.failed, got.ip, exp.bound, exp.failed, exp.ip);
    end
  endtask

  task automatic send_usr(input byte_q_t pld);
    @(posedge clk);
    foreach (pld[i]) begin
      usr_tx       <= '{data: pld[i], last: (i == pld.size() - 1)};
      usr_tx_valid <= 1'b1;
      do begin
        @(posedge clk);
      end while (!usr_tx_ready);
    end
    usr_tx_valid <= 1'b0;
  endtask

  task automatic inject_rx(input logic [31:0] sip, input logic [15:0] sp,
                           input logic [15:0] dp, input byte_q_t pld);
    byte_q_t pkt;
    pkt = udp_bytes(sp, dp, pld);
    @(posedge clk);
    ipv4_rx_meta <= '{src_ip: sip, dst_ip: OFFER_IP, length: 16'(pkt.size())};
    foreach (pkt[i]) begin
      ipv4_rx       <= '{data: pkt[i], last: (i == pkt.size() - 1)};
      ipv4_rx_valid <= 1'b1;
      do begin
        @(posedge clk);
      end while (!ipv4_rx_ready);
    end
    ipv4_rx_valid <= 1'b0;
  endtask

  // Scoreboard for the IPv4 transmit stream
  always @(posedge clk) begin
    if (rst_n && ipv4_tx_valid && ipv4_tx_ready) begin
      if (exp_tx.size() == 0 || exp_tx_meta.size() == 0) begin
        proto_errs++;
        $display("A byte left on ipv4_tx at %0t while no packet was expected", $time);
      end else begin
        if (tx_first) begin
          tx_start = $time;
          check_ipv4_meta(ipv4_tx_meta, exp_tx_meta[0]);
        end
        check_ipv4_byte(ipv4_tx, exp_tx.pop_front(), "ipv4_tx");
        if (ipv4_tx.last) begin
          void'(exp_tx_meta.pop_front());
        end
      end
      tx_first = ipv4_tx.last;
      if (ipv4_tx.last) begin
        tx_end = $time;
        tx_done++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && usr_rx_valid && usr_rx_ready) begin
      if (exp_rx.size() == 0 || exp_rx_meta.size() == 0) begin
        proto_errs++;
        $display("A byte left on usr_rx at %0t while no packet was expected", $time);
      end else begin
        if (rx_first) begin
          check_udp_meta(usr_rx_meta, exp_rx_meta[0]);
        end
        check_ipv4_byte(usr_rx, exp_rx.pop_front(), "usr_rx");
        if (usr_rx.last) begin
          void'(exp_rx_meta.pop_front());
        end
      end
      rx_first = usr_rx.last;
      if (usr_rx.last) begin
        rx_done++;
      end
    end
  end

  initial begin : watchdog
    int cycle;
    cycle = 0;
    while (cycle < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle++;
    end
    $display("The run hit its limit of %0d cycles before all packets were seen", CYCLE_LIMIT);
    $display("value errors %0d, protocol errors %0d", val_errs, proto_errs + 1);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    byte_q_t     pld;
    byte_q_t     early;
    byte_q_t     disc;
    logic [31:0] sip;
    logic [15:0] sp;
    time         first_end;
    int          disc_gap;
    void'($urandom(90));
    rst_n         = 1'b0;
    ipv4_rx       = '0;
    ipv4_rx_meta  = '0;
    ipv4_rx_valid = 1'b0;
    ipv4_tx_ready = 1'b0;
    usr_tx        = '0;
    usr_tx_valid  = 1'b0;
    usr_rx_ready  = 1'b0;
    usr_ctl       = '{loc_port: USR_PORT, rem_port: 16'd7000, rem_ip: 32'h0a00_0002};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_stat(dhcp_stat, udp_pkg::dhcp_stat_t'{bound: 1'b0, failed: 1'b0, ip: 32'h0});

    // First DISCOVER goes unanswered and the resend must match it
    disc = dhcp_bytes(8'd1, 8'd1, `DHCP_XID, 32'h0);
    expect_tx(`DHCP_CLIENT_PORT, `DHCP_SERVER_PORT, 32'h0, 32'hffff_ffff, disc);
    expect_tx(`DHCP_CLIENT_PORT, `DHCP_SERVER_PORT, 32'h0, 32'hffff_ffff, disc);
    // Held in the controller until the lease
    early = rand_payload(40);
    send_usr(early);
    while (tx_done < 1) @(posedge clk);
    first_end = tx_end;
    while (tx_done < 2) @(posedge clk);
    disc_gap = int'((tx_start - first_end) / CLK_NS);
    if (disc_gap < `DHCP_TIMEOUT_CYCLES) begin
      proto_errs++;
      $display("DISCOVER was resent after %0d cycles, before the timeout", disc_gap);
    end

    expect_tx(`DHCP_CLIENT_PORT, `DHCP_SERVER_PORT, 32'h0, 32'hffff_ffff,
              dhcp_bytes(8'd1, 8'd3, `DHCP_XID, OFFER_IP));
    inject_rx(SERVER_IP, `DHCP_SERVER_PORT, `DHCP_CLIENT_PORT,
              dhcp_bytes(8'd2, 8'd2, ~`DHCP_XID, 32'h0a00_00c8));
    inject_rx(SERVER_IP, `DHCP_SERVER_PORT, `DHCP_CLIENT_PORT,
              dhcp_bytes(8'd2, 8'd2, `DHCP_XID, OFFER_IP));
    while (tx_done < 3) @(posedge clk);
    expect_tx(USR_PORT, usr_ctl.rem_port, OFFER_IP, usr_ctl.rem_ip, early);
    inject_rx(SERVER_IP, `DHCP_SERVER_PORT, `DHCP_CLIENT_PORT,
              dhcp_bytes(8'd2, 8'd5, `DHCP_XID, OFFER_IP));
    for (int i = 0; i < 8 && !dhcp_stat.bound; i++) @(posedge clk);
    check_stat(dhcp_stat, udp_pkg::dhcp_stat_t'{bound: 1'b1, failed: 1'b0, ip: OFFER_IP});

    for (int k = 0; k < TX_PKTS; k++) begin
      pld = rand_payload(40);
      expect_tx(USR_PORT, usr_ctl.rem_port, OFFER_IP, usr_ctl.rem_ip, pld);
      send_usr(pld);
    end
    while (tx_done < 4 + TX_PKTS) @(posedge clk);

    for (int k = 0; k < RX_PKTS; k++) begin
      if (k % 3 == 1) begin
        // Unowned port
        inject_rx(32'h0a00_0009, 16'd1234, USR_PORT + 16'd1, rand_payload(24));
      end
      sip = $urandom;
      sp  = 16'($urandom);
      pld = rand_payload(32);
      expect_rx(sip, sp, pld);
      inject_rx(sip, sp, USR_PORT, pld);
    end
    while (rx_done < RX_PKTS) @(posedge clk);

    if (exp_tx.size() != 0 || exp_rx.size() != 0) begin
      proto_errs++;
      $display("Some expected bytes never appeared on the outputs");
    end
    $display("value errors %0d, protocol errors %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : udp_tb

/* src.f */
+incdir+hdl
hdl/udp_pkg.sv
hdl/udp_tx_ctl.sv
hdl/udp_core.sv
hdl/dhcp_client.sv
hdl/udp_top.sv
sim/udp_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the UDP testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module udp_tb -f src.f -o udp_tb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/udp_tb_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -qx "Simulation passed" sim.log && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
